//--- logic/ex_pkg.sv
package ex_pkg;

    localparam int XLEN       = 32;  // data word
    localparam int REG_ADDR_W = 5;   // gpr index

    // execute opcodes, grouped by class
    typedef enum logic [4:0] {
        OR, AND, XOR, NOR,
        SLL, SRL, SRA,
        MOV, MFHI, MFLO, MTHI, MTLO,
        ADD, ADDU, SUB, SUBU, MUL, SLT, SLTU, CLZ, CLO,
        MULT, MULTU, MADD, MADDU, MSUB, MSUBU,
        NOP
    } ex_op_e;

    // which unit supplies the written word
    typedef enum logic [1:0] {
        SEL_ALU,
        SEL_HILO,
        SEL_NONE
    } ex_sel_e;

    typedef struct packed {
        ex_op_e                 op;
        ex_sel_e                sel;
        logic [XLEN-1:0]        src1;    // rs
        logic [XLEN-1:0]        src2;    // rt or immediate
        logic [REG_ADDR_W-1:0]  waddr;
        logic                   reg_we;
    } ex_req_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]  waddr;
        logic                   reg_we;
        logic [XLEN-1:0]        data;
        logic                   ovf;     // signed add/sub overflow
    } ex_rsp_t;

    typedef struct packed {
        logic [XLEN-1:0]        data;
        logic                   ovf;
    } alu_out_t;

    typedef enum logic {
        HL_IDLE,
        HL_ACCUM  // product latched, accumulate pending
    } hilo_state_e;

endpackage

//--- logic/ex_alu.sv
`timescale 1ns/1ns

module ex_alu (
    input  ex_pkg::ex_req_t     req_i,
    output ex_pkg::alu_out_t    alu_o
);

    logic [ex_pkg::XLEN-1:0] sum;      // src1 + src2
    logic [ex_pkg::XLEN-1:0] diff;     // src1 - src2
    logic [ex_pkg::XLEN-1:0] prod_lo;  // low word of signed product
    logic [4:0]              shamt;
    logic                    a_msb;
    logic                    b_msb;
    logic                    add_ovf;
    logic                    sub_ovf;
    logic [ex_pkg::XLEN-1:0] res;

    // count of leading bits equal to b, scanning from the msb
    function automatic logic [ex_pkg::XLEN-1:0] lead_count(
        input logic [ex_pkg::XLEN-1:0] w,
        input logic                    b
    );
        logic [ex_pkg::XLEN-1:0] n;
        logic                    run;
        n   = '0;
        run = 1'b1;
        for (int i = ex_pkg::XLEN - 1; i >= 0; i--) begin
            if (run && (w[i] == b)) begin
                n = n + 1'b1;
            end else begin
                run = 1'b0;  // first differing bit ends the run
            end
        end
        return n;
    endfunction

    assign shamt   = req_i.src2[4:0];
    assign sum     = req_i.src1 + req_i.src2;
    assign diff    = req_i.src1 - req_i.src2;
    assign prod_lo = $signed(req_i.src1) * $signed(req_i.src2);

    assign a_msb = req_i.src1[ex_pkg::XLEN-1];
    assign b_msb = req_i.src2[ex_pkg::XLEN-1];

    // same signs in, different sign out
    assign add_ovf = (~a_msb & ~b_msb & sum[ex_pkg::XLEN-1]) |
                     ( a_msb &  b_msb & ~sum[ex_pkg::XLEN-1]);
    // signs differ and result flips away from src1
    assign sub_ovf = (~a_msb &  b_msb & diff[ex_pkg::XLEN-1]) |
                     ( a_msb & ~b_msb & ~diff[ex_pkg::XLEN-1]);

    always_comb begin
        res = '0;
        case (req_i.op)
            ex_pkg::OR: begin
                res = req_i.src1 | req_i.src2;
            end
            ex_pkg::AND: begin
                res = req_i.src1 & req_i.src2;
            end
            ex_pkg::XOR: begin
                res = req_i.src1 ^ req_i.src2;
            end
            ex_pkg::NOR: begin
                res = ~(req_i.src1 | req_i.src2);
            end
            ex_pkg::SLL: begin
                res = req_i.src1 << shamt;
            end
            ex_pkg::SRL: begin
                res = req_i.src1 >> shamt;
            end
            ex_pkg::SRA: begin
                res = $signed(req_i.src1) >>> shamt;  // sign fill
            end
            ex_pkg::MOV: begin
                res = req_i.src1;  // movn/movz condition resolved earlier
            end
            ex_pkg::ADD, ex_pkg::ADDU: begin
                res = sum;
            end
            ex_pkg::SUB, ex_pkg::SUBU: begin
                res = diff;
            end
            ex_pkg::MUL: begin
                res = prod_lo;
            end
            ex_pkg::SLT: begin
                res[0] = $signed(req_i.src1) < $signed(req_i.src2);
            end
            ex_pkg::SLTU: begin
                res[0] = req_i.src1 < req_i.src2;
            end
            ex_pkg::CLZ: begin
                res = lead_count(req_i.src1, 1'b0);
            end
            ex_pkg::CLO: begin
                res = lead_count(req_i.src1, 1'b1);
            end
            default: begin
                res = '0;  // hi/lo ops and nop
            end
        endcase
    end

    assign alu_o.data = res;
    assign alu_o.ovf  = ((req_i.op == ex_pkg::ADD) && add_ovf) ||
                        ((req_i.op == ex_pkg::SUB) && sub_ovf);

endmodule

//--- logic/ex_hilo_unit.sv
`timescale 1ns/1ns

module ex_hilo_unit (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  ex_pkg::ex_req_t             req_i,
    input  logic                        issue_i,      // request accepted this edge
    input  logic                        slot_free_i,  // output register can load
    output logic [ex_pkg::XLEN-1:0]     hilo_data_o,
    output logic                        busy_o,
    output logic                        defer_o,
    output logic                        done_o
);

    ex_pkg::hilo_state_e            state_q;
    logic [ex_pkg::XLEN-1:0]        hi_q;
    logic [ex_pkg::XLEN-1:0]        lo_q;
    logic [2*ex_pkg::XLEN-1:0]      temp_q;   // latched product
    logic                           sub_q;    // msub/msubu pending
    logic signed [2*ex_pkg::XLEN-1:0] prod_s;
    logic [2*ex_pkg::XLEN-1:0]      prod_u;
    logic [2*ex_pkg::XLEN-1:0]      acc;
    logic                           is_mac;
    logic                           mac_signed;
    logic                           mac_sub;

    assign prod_s = $signed(req_i.src1) * $signed(req_i.src2);
    assign prod_u = req_i.src1 * req_i.src2;

    // op-class decode for the accumulate group
    always_comb begin
        is_mac     = 1'b0;
        mac_signed = 1'b0;
        mac_sub    = 1'b0;
        case (req_i.op)
            ex_pkg::MADD: begin
                is_mac     = 1'b1;
                mac_signed = 1'b1;
            end
            ex_pkg::MADDU: begin
                is_mac     = 1'b1;
            end
            ex_pkg::MSUB: begin
                is_mac     = 1'b1;
                mac_signed = 1'b1;
                mac_sub    = 1'b1;
            end
            ex_pkg::MSUBU: begin
                is_mac     = 1'b1;
                mac_sub    = 1'b1;
            end
            default: begin
                is_mac     = 1'b0;
            end
        endcase
    end

    assign acc = sub_q ? ({hi_q, lo_q} - temp_q) : ({hi_q, lo_q} + temp_q);

    assign busy_o  = (state_q == ex_pkg::HL_ACCUM);
    assign defer_o = issue_i && is_mac;
    assign done_o  = busy_o && slot_free_i;  // accumulate lands with its response

    // mfhi/mflo read straight from the registers
    assign hilo_data_o = (req_i.op == ex_pkg::MFHI) ? hi_q :
                         (req_i.op == ex_pkg::MFLO) ? lo_q : '0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ex_pkg::HL_IDLE;
            hi_q    <= '0;
            lo_q    <= '0;
        end else begin
            case (state_q)
                ex_pkg::HL_IDLE: begin
                    if (issue_i) begin
                        case (req_i.op)
                            ex_pkg::MTHI:  hi_q <= req_i.src1;
                            ex_pkg::MTLO:  lo_q <= req_i.src1;
                            ex_pkg::MULT:  {hi_q, lo_q} <= prod_s;
                            ex_pkg::MULTU: {hi_q, lo_q} <= prod_u;
                            default: begin
                                if (is_mac) begin
                                    state_q <= ex_pkg::HL_ACCUM;
                                end
                            end
                        endcase
                    end
                end
                ex_pkg::HL_ACCUM: begin
                    if (slot_free_i) begin  // else hold, hi/lo untouched
                        {hi_q, lo_q} <= acc;
                        state_q      <= ex_pkg::HL_IDLE;
                    end
                end
                default: begin
                    state_q <= ex_pkg::HL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (defer_o) begin
            temp_q <= mac_signed ? prod_s : prod_u;
            sub_q  <= mac_sub;
        end
    end

endmodule

//--- logic/ex_retire.sv
`timescale 1ns/1ns

module ex_retire (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        req_valid_i,
    input  ex_pkg::ex_req_t             req_i,
    output logic                        req_ready_o,
    input  ex_pkg::alu_out_t            alu_i,
    input  logic [ex_pkg::XLEN-1:0]     hilo_data_i,
    input  logic                        busy_i,
    input  logic                        defer_i,
    input  logic                        done_i,
    output logic                        issue_o,
    output logic                        slot_free_o,
    output logic                        rsp_valid_o,
    output ex_pkg::ex_rsp_t             rsp_o,
    input  logic                        rsp_ready_i
);

    ex_pkg::ex_rsp_t                    rsp_q;
    ex_pkg::ex_rsp_t                    rsp_d;
    logic                               rsp_valid_q;
    logic                               load;
    logic [ex_pkg::REG_ADDR_W-1:0]      pend_waddr_q;  // deferred op destination
    logic                               pend_we_q;

    assign slot_free_o = !rsp_valid_q || rsp_ready_i;  // empty or draining
    assign req_ready_o = slot_free_o && !busy_i;
    assign issue_o     = req_valid_i && req_ready_o;
    assign load        = (issue_o && !defer_i) || done_i;

    always_comb begin
        rsp_d = '0;
        if (done_i) begin
            rsp_d.waddr  = pend_waddr_q;  // accumulate completes, no data
            rsp_d.reg_we = pend_we_q;
        end else begin
            rsp_d.waddr  = req_i.waddr;
            rsp_d.reg_we = req_i.reg_we && !alu_i.ovf;  // drop write on overflow
            rsp_d.ovf    = alu_i.ovf;
            case (req_i.sel)
                ex_pkg::SEL_ALU:  rsp_d.data = alu_i.data;
                ex_pkg::SEL_HILO: rsp_d.data = hilo_data_i;
                default:          rsp_d.data = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (load) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            rsp_q <= rsp_d;
        end
        if (issue_o && defer_i) begin
            pend_waddr_q <= req_i.waddr;
            pend_we_q    <= req_i.reg_we;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

//--- logic/ex_stage.sv
`timescale 1ns/1ns

module ex_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  ex_pkg::ex_req_t     req_i,
    output logic                req_ready_o,
    output logic                rsp_valid_o,
    output ex_pkg::ex_rsp_t     rsp_o,
    input  logic                rsp_ready_i
);

    ex_pkg::alu_out_t           alu_out;
    logic [ex_pkg::XLEN-1:0]    hilo_data;
    logic                       hilo_busy;
    logic                       hilo_defer;
    logic                       hilo_done;
    logic                       issue;      // request fire
    logic                       slot_free;

    ex_alu i_alu (
        .req_i  (req_i),
        .alu_o  (alu_out)
    );

    ex_hilo_unit i_hilo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .issue_i     (issue),
        .slot_free_i (slot_free),
        .hilo_data_o (hilo_data),
        .busy_o      (hilo_busy),
        .defer_o     (hilo_defer),
        .done_o      (hilo_done)
    );

    ex_retire i_retire (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .alu_i       (alu_out),
        .hilo_data_i (hilo_data),
        .busy_i      (hilo_busy),
        .defer_i     (hilo_defer),
        .done_i      (hilo_done),
        .issue_o     (issue),
        .slot_free_o (slot_free),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

endmodule

//--- include/ex_tb_checks.svh
`ifndef EX_TB_CHECKS_SVH
`define EX_TB_CHECKS_SVH

// compare helpers for the execute stage testbench

task automatic check_flag(
    input string                        name,
    input logic                         got,
    input logic                         exp,
    inout int                           errs
);
    if (got !== exp) begin
        errs++;
        $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_word(
    input string                        name,
    input logic [ex_pkg::XLEN-1:0]      got,
    input logic [ex_pkg::XLEN-1:0]      exp,
    inout int                           errs
);
    if (got !== exp) begin
        errs++;
        $display("** Error: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_rsp(
    input string            name,
    input ex_pkg::ex_rsp_t  got,
    input ex_pkg::ex_rsp_t  exp,
    inout int               errs
);
    if (got.waddr !== exp.waddr) begin  // destination mismatch
        errs++;
        $display("** Error: %s.waddr got 0x%02h expected 0x%02h", name, got.waddr, exp.waddr);
    end
    if (got.reg_we !== exp.reg_we) begin
        errs++;
        $display("** Error: %s.reg_we got 0x%0h expected 0x%0h", name, got.reg_we, exp.reg_we);
    end
    if (got.data !== exp.data) begin
        errs++;
        $display("** Error: %s.data got 0x%08h expected 0x%08h", name, got.data, exp.data);
    end
    if (got.ovf !== exp.ovf) begin  // overflow flag
        errs++;
        $display("** Error: %s.ovf got 0x%0h expected 0x%0h", name, got.ovf, exp.ovf);
    end
endtask

`endif

//--- bench/tb_ex_stage.sv
`timescale 1ns/1ns

module tb_ex_stage;

    localparam int CLK_PERIOD = 4;
    localparam int N_REQ      = 87;  // requests issued over all tests

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       req_valid_i;
    ex_pkg::ex_req_t            req_i;
    logic                       req_ready_o;
    logic                       rsp_valid_o;
    ex_pkg::ex_rsp_t            rsp_o;
    logic                       rsp_ready_i;

    integer                     seed;
    int                         errs;
    int                         n_tests;
    bit                         stall_on;  // random back-pressure on rsp_ready_i
    logic [ex_pkg::XLEN-1:0]    m_hi;      // reference hi/lo
    logic [ex_pkg::XLEN-1:0]    m_lo;
    ex_pkg::ex_rsp_t            exp_q[$];
    ex_pkg::ex_rsp_t            got_q[$];
    ex_pkg::ex_rsp_t            held;
    bit                         holding;

    `include "ex_tb_checks.svh"

    ex_stage i_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        #1;
        rsp_ready_i = stall_on ? (($unsigned($random(seed)) % 3) != 0) : 1'b1;
    end

    // collect transfers and watch that a stalled response holds
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (holding && !rsp_valid_o) begin
                errs++;
                $display("response withdrawn while stalled at %0t", $time);
            end else if (holding) begin
                check_rsp("rsp_o held", rsp_o, held, errs);
            end
            if (rsp_valid_o && rsp_ready_i) begin
                got_q.push_back(rsp_o);
            end
            holding = rsp_valid_o && !rsp_ready_i;
            held    = rsp_o;
        end
    end

    // expected response with the model hi/lo updated in program order
    function automatic ex_pkg::ex_rsp_t model(input ex_pkg::ex_req_t r);
        ex_pkg::ex_rsp_t            rsp;
        logic [ex_pkg::XLEN:0]      wide;
        logic [2*ex_pkg::XLEN-1:0]  p;
        logic [ex_pkg::XLEN-1:0]    v;
        logic                       ovf;
        int                         n;
        v   = '0;
        ovf = 1'b0;
        n   = 0;
        if ((r.op == ex_pkg::MULT) || (r.op == ex_pkg::MADD) ||
            (r.op == ex_pkg::MSUB) || (r.op == ex_pkg::MUL)) begin
            p = $signed({{32{r.src1[31]}}, r.src1}) * $signed({{32{r.src2[31]}}, r.src2});
        end else begin
            p = {32'b0, r.src1} * {32'b0, r.src2};
        end
        case (r.op)
            ex_pkg::OR:    v = r.src1 | r.src2;
            ex_pkg::AND:   v = r.src1 & r.src2;
            ex_pkg::XOR:   v = r.src1 ^ r.src2;
            ex_pkg::NOR:   v = ~(r.src1 | r.src2);
            ex_pkg::SLL:   v = r.src1 << r.src2[4:0];
            ex_pkg::SRL:   v = r.src1 >> r.src2[4:0];
            ex_pkg::SRA:   v = $signed(r.src1) >>> r.src2[4:0];
            ex_pkg::MOV:   v = r.src1;
            ex_pkg::MUL:   v = p[ex_pkg::XLEN-1:0];
            ex_pkg::SLT:   v = {31'b0, $signed(r.src1) < $signed(r.src2)};
            ex_pkg::SLTU:  v = {31'b0, r.src1 < r.src2};
            ex_pkg::MFHI:  v = m_hi;
            ex_pkg::MFLO:  v = m_lo;
            ex_pkg::MTHI:  m_hi = r.src1;
            ex_pkg::MTLO:  m_lo = r.src1;
            ex_pkg::MULT, ex_pkg::MULTU: {m_hi, m_lo} = p;
            ex_pkg::MADD, ex_pkg::MADDU: {m_hi, m_lo} = {m_hi, m_lo} + p;
            ex_pkg::MSUB, ex_pkg::MSUBU: {m_hi, m_lo} = {m_hi, m_lo} - p;
            ex_pkg::ADD, ex_pkg::ADDU: begin
                wide = {r.src1[31], r.src1} + {r.src2[31], r.src2};  // one guard bit
                v    = wide[31:0];
                ovf  = (r.op == ex_pkg::ADD) && (wide[32] != wide[31]);
            end
            ex_pkg::SUB, ex_pkg::SUBU: begin
                wide = {r.src1[31], r.src1} - {r.src2[31], r.src2};
                v    = wide[31:0];
                ovf  = (r.op == ex_pkg::SUB) && (wide[32] != wide[31]);
            end
            ex_pkg::CLZ, ex_pkg::CLO: begin
                while (n < 32 && r.src1[31-n] == (r.op == ex_pkg::CLO)) begin
                    n++;
                end
                v = n;
            end
            default:       v = '0;
        endcase
        rsp.waddr  = r.waddr;
        rsp.reg_we = r.reg_we && !ovf;
        rsp.ovf    = ovf;
        rsp.data   = (r.sel == ex_pkg::SEL_NONE) ? '0 : v;
        return rsp;
    endfunction

    // one request through the handshake with an optional latency check
    task automatic send(
        input ex_pkg::ex_op_e           op,
        input logic [ex_pkg::XLEN-1:0]  a,
        input logic [ex_pkg::XLEN-1:0]  b,
        input bit                       timed
    );
        ex_pkg::ex_req_t            r;
        ex_pkg::ex_rsp_t            exp;
        logic [ex_pkg::XLEN-1:0]    rnd;
        bit                         accepted;
        bit                         mac;
        mac      = (op == ex_pkg::MADD) || (op == ex_pkg::MADDU) ||
                   (op == ex_pkg::MSUB) || (op == ex_pkg::MSUBU);
        rnd      = $random(seed);
        r.op     = op;
        r.src1   = a;
        r.src2   = b;
        r.waddr  = rnd[ex_pkg::REG_ADDR_W-1:0];
        if ((op == ex_pkg::MFHI) || (op == ex_pkg::MFLO)) begin
            r.sel    = ex_pkg::SEL_HILO;
            r.reg_we = 1'b1;
        end else if (mac || (op == ex_pkg::MTHI) || (op == ex_pkg::MTLO) ||
                     (op == ex_pkg::MULT) || (op == ex_pkg::MULTU) ||
                     (op == ex_pkg::NOP)) begin
            r.sel    = ex_pkg::SEL_NONE;
            r.reg_we = 1'b0;
        end else begin
            r.sel    = ex_pkg::SEL_ALU;
            r.reg_we = 1'b1;
        end
        exp = model(r);
        exp_q.push_back(exp);
        req_valid_i = 1'b1;
        req_i       = r;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = req_ready_o;  // ready never looks at valid
            @(posedge clk_i);
        end
        #1;
        req_valid_i = 1'b0;
        req_i       = '0;  // no payload between requests
        req_i.op    = ex_pkg::NOP;
        if (timed) begin
            @(negedge clk_i);
            if (mac) begin
                check_flag("rsp_valid_o", rsp_valid_o, 1'b0, errs);
                check_flag("req_ready_o", req_ready_o, 1'b0, errs);
                @(negedge clk_i);  // accumulate lands one edge later
            end
            check_flag("rsp_valid_o", rsp_valid_o, 1'b1, errs);
            check_rsp("rsp_o", rsp_o, exp, errs);
            @(posedge clk_i);
            #1;
        end
    endtask

    // wait for all responses and compare them in order
    task automatic drain();
        while (got_q.size() < exp_q.size()) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        #1;
        if (got_q.size() != exp_q.size()) begin
            errs++;
            $display("%0d responses received for %0d requests", got_q.size(), exp_q.size());
        end
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            check_rsp("rsp_o", got_q.pop_front(), exp_q.pop_front(), errs);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic report(input string name, input int start);
        n_tests++;
        if (errs == start) begin
            $display("%s passed", name);
        end else begin
            $display("%s failed with %0d errors", name, errs - start);
        end
    endtask

    task automatic reset_values();
        int start;
        start = errs;
        @(negedge clk_i);
        check_flag("rsp_valid_o", rsp_valid_o, 1'b0, errs);
        check_flag("req_ready_o", req_ready_o, 1'b1, errs);
        @(posedge clk_i);
        #1;
        send(ex_pkg::MFHI, $random(seed), $random(seed), 1'b1);
        send(ex_pkg::MFLO, $random(seed), $random(seed), 1'b1);
        drain();
        report("reset", start);
    endtask

    task automatic logic_and_shift();
        ex_pkg::ex_op_e ops[8];
        int             start;
        start = errs;
        ops   = '{ex_pkg::OR, ex_pkg::AND, ex_pkg::XOR, ex_pkg::NOR,
                  ex_pkg::SLL, ex_pkg::SRL, ex_pkg::SRA, ex_pkg::MOV};
        repeat (2) begin
            foreach (ops[i]) begin
                send(ops[i], $random(seed), $random(seed), 1'b1);
            end
        end
        drain();
        report("logic_shift", start);
    endtask

    task automatic arithmetic();
        ex_pkg::ex_op_e ops[7];
        int             start;
        start = errs;
        ops   = '{ex_pkg::ADDU, ex_pkg::SUBU, ex_pkg::SLT, ex_pkg::SLTU,
                  ex_pkg::MUL, ex_pkg::CLZ, ex_pkg::CLO};
        foreach (ops[i]) begin
            send(ops[i], $random(seed), $random(seed), 1'b1);
        end
        send(ex_pkg::CLZ, 32'h0, $random(seed), 1'b1);          // count of 32
        send(ex_pkg::CLO, 32'hffff_ffff, $random(seed), 1'b1);
        send(ex_pkg::ADD, 32'h7fff_ffff, 32'h0000_0001, 1'b1);  // overflows
        send(ex_pkg::SUB, 32'h8000_0000, 32'h0000_0001, 1'b1);  // overflows
        send(ex_pkg::ADD, 32'h0000_1234, 32'hffff_fff0, 1'b1);
        send(ex_pkg::SUB, 32'h8000_0000, 32'h8000_0001, 1'b1);
        drain();
        report("arith", start);
    endtask

    task automatic hilo_moves();
        int start;
        start = errs;
        send(ex_pkg::MTHI, $random(seed), 32'h0, 1'b1);
        send(ex_pkg::MTLO, $random(seed), 32'h0, 1'b1);
        send(ex_pkg::MFHI, 32'h0, 32'h0, 1'b1);
        send(ex_pkg::MFLO, 32'h0, 32'h0, 1'b1);
        send(ex_pkg::MULT, $random(seed) | 32'h8000_0000, $random(seed), 1'b1);
        send(ex_pkg::MFHI, 32'h0, 32'h0, 1'b1);
        send(ex_pkg::MFLO, 32'h0, 32'h0, 1'b1);
        send(ex_pkg::MULTU, $random(seed) | 32'h8000_0000, 32'hffff_fffb, 1'b1);
        send(ex_pkg::MFHI, 32'h0, 32'h0, 1'b1);
        send(ex_pkg::MFLO, 32'h0, 32'h0, 1'b1);
        drain();
        report("hilo", start);
    endtask

    task automatic multiply_accumulate();
        ex_pkg::ex_op_e ops[4];
        int             start;
        start = errs;
        ops   = '{ex_pkg::MADD, ex_pkg::MADDU, ex_pkg::MSUB, ex_pkg::MSUBU};
        foreach (ops[i]) begin
            send(ex_pkg::MTHI, $random(seed), 32'h0, 1'b1);
            send(ex_pkg::MTLO, $random(seed), 32'h0, 1'b1);
            send(ops[i], $random(seed), $random(seed) | 32'h8000_0000, 1'b1);
            send(ex_pkg::MFHI, 32'h0, 32'h0, 1'b1);
            send(ex_pkg::MFLO, 32'h0, 32'h0, 1'b1);
        end
        drain();
        report("mac", start);
    endtask

    task automatic backpressure_stream();
        ex_pkg::ex_op_e ops[16];
        int             start;
        int             idx;
        start    = errs;
        ops      = '{ex_pkg::OR, ex_pkg::XOR, ex_pkg::SLL, ex_pkg::SRA, ex_pkg::ADDU,
                     ex_pkg::SUB, ex_pkg::SLT, ex_pkg::MUL, ex_pkg::CLZ, ex_pkg::MTHI,
                     ex_pkg::MTLO, ex_pkg::MULT, ex_pkg::MADD, ex_pkg::MSUBU,
                     ex_pkg::MFHI, ex_pkg::MFLO};
        stall_on = 1'b1;
        repeat (24) begin
            idx = $unsigned($random(seed)) % 16;
            send(ops[idx], $random(seed), $random(seed), 1'b0);
        end
        send(ex_pkg::MFHI, 32'h0, 32'h0, 1'b0);
        send(ex_pkg::MFLO, 32'h0, 32'h0, 1'b0);
        drain();
        stall_on = 1'b0;
        report("backpressure", start);
    endtask

    initial begin
        seed        = 32'h8ab5_8c96;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        req_i.op    = ex_pkg::NOP;
        rsp_ready_i = 1'b1;
        stall_on    = 1'b0;
        holding     = 1'b0;
        errs        = 0;
        n_tests     = 0;
        m_hi        = '0;
        m_lo        = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        reset_values();
        logic_and_shift();
        arithmetic();
        hilo_moves();
        multiply_accumulate();
        backpressure_stream();
        $display("%0d tests run, %0d errors", n_tests, errs);
        if (errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((N_REQ * 8 + 3) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", N_REQ * 8 + 3);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_hilo_unit.sv
logic/ex_retire.sv
logic/ex_stage.sv
bench/tb_ex_stage.sv
